// File: compile.f
common/iso14443a_pkg.sv
design/sequence_detect.sv
frame_decode/frame_decode.sv
frame_decode/rx_byte_assembler.sv
frame_decode/frame_event_checker.sv
design/iso14443a_rx_top.sv
verification/iso14443a_rx_tb.sv

// File: Makefile
# Verilator build and run of the type A receive path testbench
# any variable below can be set on the command line, e.g. make test LOG=run.log

VERILATOR ?= verilator
TOP       ?= iso14443a_rx_tb
FILE_LIST ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  ?= SIMULATION FAILED
PASS_MSG  ?= SIMULATION PASSED

.DEFAULT_GOAL := help
.PHONY: help test build clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and search $(LOG) for the fail message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

test: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "test failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "no result in $(LOG)"; exit 1; fi
	@echo "test passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: verification/iso14443a_rx_tb.sv
// testbench for the type A receive path
// table rows become Miller pause waveforms, events are checked against a queue
`default_nettype none
`timescale 1ns/1ps

module iso14443a_rx_tb;

    localparam int bit_ticks    = iso14443a_pkg::DEFAULT_BIT_TICKS;
    localparam int half         = bit_ticks / 2;
    localparam int pause_len    = bit_ticks / 4;
    localparam int num_rows     = 9;
    localparam int idle_periods = 4;
    localparam int drain_limit  = 40 * bit_ticks;

    // ========================================================================
    // frame table
    // ========================================================================

    // whole bytes, trailing bits, byte with flipped parity, bit paused in both halves
    // -1 stands for none, the error index counts payload bits including parity
    int row_bytes [num_rows] = '{2, 0, 1, 3, 2, 1, 3, 0, 2};
    int row_trail [num_rows] = '{0, 7, 3, 0, 0, 0, 0, 0, 5};
    int row_flip  [num_rows] = '{-1, -1, -1, 1, -1, -1, -1, -1, 0};
    int row_err   [num_rows] = '{-1, -1, -1, -1, 5, -1, 20, -1, -1};

    logic                        clk;
    logic                        reset;
    logic                        pause;
    iso14443a_pkg::frame_event_t frame_event;
    logic                        protocol_fault;

    // expected events, with a mask of the data bits that carry meaning
    iso14443a_pkg::frame_event_t exp_q [$];
    logic [7:0]                  mask_q [$];

    integer seed;
    int     errors;
    int     checks;
    int     events_seen;
    logic   fault_reported;
    logic   drained;

    iso14443a_rx_top #(
        .bit_ticks (bit_ticks)
    ) uut (
        .clk            (clk),
        .reset          (reset),
        .pause          (pause),
        .frame_event    (frame_event),
        .protocol_fault (protocol_fault)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    // inputs change 2 ns after the edge so the DUT samples them one edge later
    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    // one bit period, Z pauses early, X pauses from the middle on, ERR does both
    task automatic drive_period(input iso14443a_pkg::seq_t kind);
        logic first;
        logic second;
        first  = (kind == iso14443a_pkg::SEQ_Z) || (kind == iso14443a_pkg::SEQ_ERR);
        second = (kind == iso14443a_pkg::SEQ_X) || (kind == iso14443a_pkg::SEQ_ERR);
        for (int p = 0; p < bit_ticks; p++) begin
            pause = (first && (p < pause_len))
                  || (second && (p >= half) && (p < half + pause_len));
            next_cycle();
        end
    endtask

    task automatic expect_event(input logic soc, input logic eoc, input logic seq_err,
                                input logic par_err, input logic dv, input logic [2:0] nbits,
                                input logic [7:0] data, input logic [7:0] mask);
        iso14443a_pkg::frame_event_t e;
        e                = '0;
        e.soc            = soc;
        e.eoc            = eoc;
        e.sequence_error = seq_err;
        e.parity_error   = par_err;
        e.data_valid     = dv;
        e.data_bits      = nbits;
        e.data           = data;
        exp_q.push_back(e);
        mask_q.push_back(mask);
    endtask

    // a whole byte turns into a parity error when its parity bit was flipped
    task automatic expect_byte(input logic [7:0] data, input logic flipped);
        if (flipped) begin
            expect_event(1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 3'd0, 8'h00, 8'h00);
        end else begin
            expect_event(1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 3'd0, data, 8'hff);
        end
    endtask

    // ========================================================================
    // one table row: payload, expected events, then the pause waveform
    // ========================================================================

    task automatic run_row(input int r);
        logic [7:0] payload [4];
        logic [7:0] trail;
        logic       stream [$];
        logic       last;
        integer     rnd;
        int         delivered;
        for (int b = 0; b < row_bytes[r]; b++) begin
            rnd        = $random(seed);
            payload[b] = rnd[7:0];
            for (int i = 0; i < 8; i++) begin
                stream.push_back(payload[b][i]);
            end
            // odd parity bit, inverted on the row's bad byte
            stream.push_back((~^payload[b]) ^ (b == row_flip[r]));
        end
        rnd   = $random(seed);
        trail = rnd[7:0];
        for (int i = 0; i < row_trail[r]; i++) begin
            stream.push_back(trail[i]);
        end

        expect_event(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 3'd0, 8'h00, 8'h00);
        if (row_err[r] < 0) begin
            for (int b = 0; b < row_bytes[r]; b++) begin
                expect_byte(payload[b], b == row_flip[r]);
            end
            if (row_trail[r] > 0) begin
                expect_event(1'b0, 1'b1, 1'b0, 1'b0, 1'b1, 3'(row_trail[r]), trail,
                             8'((1 << row_trail[r]) - 1));
            end else begin
                expect_event(1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 3'd0, 8'h00, 8'h00);
            end
        end else begin
            // the bit held back when the bad period arrives never comes out
            delivered = (row_err[r] > 0) ? row_err[r] - 1 : 0;
            for (int b = 0; b < delivered / 9; b++) begin
                expect_byte(payload[b], b == row_flip[r]);
            end
            expect_event(1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 3'd0, 8'h00, 8'h00);
        end

        // start is a Z, a 0 after a 0 is Z, after a 1 it is Y
        drive_period(iso14443a_pkg::SEQ_Z);
        last = 1'b0;
        for (int i = 0; i < stream.size(); i++) begin
            if (i == row_err[r]) begin
                drive_period(iso14443a_pkg::SEQ_ERR);
                break;
            end
            drive_period(stream[i] ? iso14443a_pkg::SEQ_X
                                   : (last ? iso14443a_pkg::SEQ_Y : iso14443a_pkg::SEQ_Z));
            last = stream[i];
        end
        if (row_err[r] < 0) begin
            drive_period(last ? iso14443a_pkg::SEQ_Y : iso14443a_pkg::SEQ_Z);
            drive_period(iso14443a_pkg::SEQ_Y);
        end
        // quiet field lets the sampler fall back to idle before the next row
        repeat (idle_periods) drive_period(iso14443a_pkg::SEQ_Y);
    endtask

    task automatic wait_drain(output logic done);
        int waited;
        waited = 0;
        while ((exp_q.size() != 0) && (waited < drain_limit)) begin
            next_cycle();
            waited++;
        end
        done = (exp_q.size() == 0);
    endtask

    // ========================================================================
    // event monitor, samples on the falling edge where outputs are settled
    // ========================================================================

    function automatic logic [4:0] flag_bits(input iso14443a_pkg::frame_event_t e);
        return {e.soc, e.eoc, e.sequence_error, e.parity_error, e.data_valid};
    endfunction

    task automatic check_value(input string name, input logic [7:0] got,
                               input logic [7:0] want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("Fail at %0t ns: %s is %0h, expected %0h", $time, name, got, want);
        end
    endtask

    task automatic compare_event(input iso14443a_pkg::frame_event_t got,
                                 input iso14443a_pkg::frame_event_t want,
                                 input logic [7:0] mask);
        check_value("frame_event.soc", 8'(got.soc), 8'(want.soc));
        check_value("frame_event.eoc", 8'(got.eoc), 8'(want.eoc));
        check_value("frame_event.sequence_error", 8'(got.sequence_error),
                    8'(want.sequence_error));
        check_value("frame_event.parity_error", 8'(got.parity_error), 8'(want.parity_error));
        check_value("frame_event.data_valid", 8'(got.data_valid), 8'(want.data_valid));
        check_value("frame_event.data_bits", 8'(got.data_bits), 8'(want.data_bits));
        check_value("frame_event.data", got.data & mask, want.data & mask);
    endtask

    always @(negedge clk) begin
        if (reset) begin
            if ((flag_bits(frame_event) !== 5'd0) || (protocol_fault !== 1'b0)) begin
                errors++;
                $display("event flag or protocol_fault set during reset at %0t ns", $time);
            end
        end else begin
            // a sticky fault is reported once
            if ((protocol_fault !== 1'b0) && !fault_reported) begin
                fault_reported = 1'b1;
                errors++;
                $display("Fail at %0t ns: protocol_fault is %b, expected 0", $time,
                         protocol_fault);
            end
            if (flag_bits(frame_event) !== 5'd0) begin
                events_seen++;
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("event at %0t ns that no table row explains", $time);
                end else begin
                    compare_event(frame_event, exp_q.pop_front(), mask_q.pop_front());
                end
            end
        end
    end

    initial begin
        seed           = 21;
        errors         = 0;
        checks         = 0;
        events_seen    = 0;
        fault_reported = 1'b0;
        drained        = 1'b1;
        reset          = 1'b1;
        pause          = 1'b0;
        repeat (8) @(posedge clk);
        #2;
        reset = 1'b0;
        repeat (4) next_cycle();

        for (int r = 0; r < num_rows; r++) begin
            run_row(r);
            wait_drain(drained);
            if (!drained) begin
                errors++;
                $display("timeout waiting for the events of table row %0d", r);
                break;
            end
        end
        // a quiet tail catches late or extra events
        repeat (2 * bit_ticks) next_cycle();

        $display("checks %0d, events %0d, errors %0d", checks, events_seen, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: design/iso14443a_rx_top.sv
// top level of the type A receive path
// pause sampler, Miller decoder, byte assembler and event checker in a chain
`default_nettype none
`timescale 1ns/1ps

module iso14443a_rx_top #(
    parameter int bit_ticks = iso14443a_pkg::DEFAULT_BIT_TICKS
) (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        pause,
    output iso14443a_pkg::frame_event_t frame_event,
    output logic                        protocol_fault
);

    iso14443a_pkg::rx_seq_t seq;
    iso14443a_pkg::rx_bit_t bits;

    // only the sampler needs the bit period length
    sequence_detect #(
        .bit_ticks (bit_ticks)
    ) u_sequence_detect (
        .clk   (clk),
        .reset (reset),
        .pause (pause),
        .seq   (seq)
    );

    frame_decode u_frame_decode (
        .clk   (clk),
        .reset (reset),
        .seq   (seq),
        .bits  (bits)
    );

    rx_byte_assembler u_rx_byte_assembler (
        .clk         (clk),
        .reset       (reset),
        .bits        (bits),
        .frame_event (frame_event)
    );

    // watches the same events that leave the top level
    frame_event_checker u_frame_event_checker (
        .clk            (clk),
        .reset          (reset),
        .frame_event    (frame_event),
        .protocol_fault (protocol_fault)
    );

endmodule

`default_nettype wire

// File: frame_decode/frame_event_checker.sv
// rule checker on the frame event stream
// raises a sticky protocol fault on any illegal event or ordering
`default_nettype none
`timescale 1ns/1ps

module frame_event_checker (
    input  logic                        clk,
    input  logic                        reset,
    input  iso14443a_pkg::frame_event_t frame_event,
    output logic                        protocol_fault
);

    logic [4:0] flags;
    logic [4:0] flags_q;
    logic       frame_open;
    logic       fault_now;

    // returns 0 when the flags of one event contradict each other
    function automatic logic is_legal(input iso14443a_pkg::frame_event_t e);
        logic ok;
        ok = 1'b1;
        if (e.soc && (e.eoc || e.sequence_error || e.parity_error || e.data_valid)) begin
            ok = 1'b0;
        end
        if (e.soc && (e.data_bits != 3'd0)) begin
            ok = 1'b0;
        end
        if (e.sequence_error && (e.parity_error || e.data_valid)) begin
            ok = 1'b0;
        end
        // a parity error belongs to a whole byte and never rides on eoc
        if (e.parity_error && (e.data_valid || e.eoc)) begin
            ok = 1'b0;
        end
        // data goes with a bit count exactly when it rides on eoc
        if (e.data_valid && (e.eoc != (e.data_bits != 3'd0))) begin
            ok = 1'b0;
        end
        return ok;
    endfunction

    assign flags = {frame_event.soc, frame_event.eoc, frame_event.sequence_error,
                    frame_event.parity_error, frame_event.data_valid};

    assign fault_now = !is_legal(frame_event)
                     || ((flags & flags_q) != 5'd0)
                     || (!frame_open && (frame_event.eoc || frame_event.data_valid
                                         || frame_event.parity_error))
                     || (frame_open && frame_event.soc);

    always_ff @(posedge clk) begin
        if (reset) begin
            flags_q        <= '0;
            frame_open     <= 1'b0;
            protocol_fault <= 1'b0;
        end else begin
            flags_q        <= flags;
            protocol_fault <= protocol_fault | fault_now;
            if (frame_event.soc) begin
                frame_open <= 1'b1;
            end else if (frame_event.eoc || frame_event.sequence_error) begin
                frame_open <= 1'b0;
            end
        end
    end

    // every flag from the assembler is a single cycle pulse
    for (genvar i = 0; i < 5; i++) begin : g_one_tick
        a_one_tick: assert property (
            @(posedge clk) disable iff (reset) flags[i] |=> !flags[i]
        ) else $error("event flag %0d high for more than one cycle", i);
    end

    a_quiet_in_reset: assert property (
        @(posedge clk) reset |=> (flags == 5'd0)
    ) else $error("event flags set during reset");

endmodule

`default_nettype wire

// File: frame_decode/rx_byte_assembler.sv
// byte assembler with odd parity check
// issues whole bytes, parity errors and the partial byte at eoc
`default_nettype none
`timescale 1ns/1ps

module rx_byte_assembler (
    input  logic                        clk,
    input  logic                        reset,
    input  iso14443a_pkg::rx_bit_t      bits,
    output iso14443a_pkg::frame_event_t frame_event
);

    localparam logic [3:0] full_count = 4'(iso14443a_pkg::BYTE_BITS);

    // byte under construction, bits land at their own index, lsb first
    logic [7:0] shift;

    // data bits collected so far, reaches 8 when the parity bit is due
    logic [3:0] count;

    // xor of the data bits received in this byte
    logic       parity;

    always_ff @(posedge clk) begin
        if (bits.valid && (count != full_count)) begin
            shift[count[2:0]] <= bits.value;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            count       <= '0;
            parity      <= 1'b0;
            frame_event <= '0;
        end else begin
            frame_event      <= '0;
            frame_event.data <= shift;
            if (bits.soc || bits.sequence_error) begin
                frame_event.soc            <= bits.soc;
                frame_event.sequence_error <= bits.sequence_error;
                count                      <= '0;
                parity                     <= 1'b0;
            end else if (bits.eoc) begin
                frame_event.eoc <= 1'b1;
                // eight bits with no parity after them can not be a legal end
                if (count == full_count) begin
                    frame_event.sequence_error <= 1'b1;
                end else if (count != '0) begin
                    frame_event.data_valid <= 1'b1;
                    frame_event.data_bits  <= count[2:0];
                end
                count  <= '0;
                parity <= 1'b0;
            end else if (bits.valid) begin
                if (count == full_count) begin
                    // odd parity, so data plus parity bit must xor to 1
                    if (parity ^ bits.value) begin
                        frame_event.data_valid <= 1'b1;
                    end else begin
                        frame_event.parity_error <= 1'b1;
                    end
                    count  <= '0;
                    parity <= 1'b0;
                end else begin
                    count  <= count + 1'b1;
                    parity <= parity ^ bits.value;
                end
            end
        end
    end

    // a partial byte answers an eoc from the decoder that carries no data bit of its own
    a_partial_only_at_eoc: assert property (
        @(posedge clk) disable iff (reset)
        (frame_event.data_bits != 3'd0) |-> (frame_event.eoc && $past(bits.eoc && !bits.valid))
    ) else $error("data_bits set without a bare eoc from the decoder");

endmodule

`default_nettype wire

// File: frame_decode/frame_decode.sv
// Miller sequence to frame bit decoder
// produces soc, eoc, sequence_error and data bits delayed by one sequence
`default_nettype none
`timescale 1ns/1ps

module frame_decode (
    input  logic                   clk,
    input  logic                   reset,
    input  iso14443a_pkg::rx_seq_t seq,
    output iso14443a_pkg::rx_bit_t bits
);

    // the state also remembers the value of the last decoded bit
    // because the legal sequence for a 0 depends on it
    typedef enum logic [1:0] {
        idle,
        in_frame_last_one,
        in_frame_last_zero
    } state_t;

    state_t state;

    // set while a decoded bit is held back, clear straight after soc
    // since the start bit is not data
    logic pending;

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= idle;
            pending <= 1'b0;
            bits    <= '0;
        end else begin
            bits <= '0;
            if (seq.valid) begin
                // the held bit matches the state, so its value comes from there
                bits.value <= (state == in_frame_last_one);
                case (state)
                    idle: begin
                        // only a Z opens a frame, anything else is line noise
                        if (seq.kind == iso14443a_pkg::SEQ_Z) begin
                            bits.soc <= 1'b1;
                            pending  <= 1'b0;
                            state    <= in_frame_last_zero;
                        end
                    end
                    in_frame_last_one: begin
                        case (seq.kind)
                            iso14443a_pkg::SEQ_X: begin
                                bits.valid <= 1'b1;
                            end
                            iso14443a_pkg::SEQ_Y: begin
                                bits.valid <= 1'b1;
                                state      <= in_frame_last_zero;
                            end
                            default: begin
                                // Z can never follow a 1 in modified Miller
                                bits.sequence_error <= 1'b1;
                                pending             <= 1'b0;
                                state               <= idle;
                            end
                        endcase
                    end
                    in_frame_last_zero: begin
                        case (seq.kind)
                            iso14443a_pkg::SEQ_X: begin
                                bits.valid <= pending;
                                pending    <= 1'b1;
                                state      <= in_frame_last_one;
                            end
                            iso14443a_pkg::SEQ_Z: begin
                                bits.valid <= pending;
                                pending    <= 1'b1;
                            end
                            iso14443a_pkg::SEQ_Y: begin
                                // end of communication, the held 0 was the marker
                                bits.eoc <= 1'b1;
                                pending  <= 1'b0;
                                state    <= idle;
                            end
                            default: begin
                                bits.sequence_error <= 1'b1;
                                pending             <= 1'b0;
                                state               <= idle;
                            end
                        endcase
                    end
                    default: begin
                        state <= idle;
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// File: design/sequence_detect.sv
// bit period tracker for the sampled pause input
// classifies each period as an X, Y or Z sequence or as illegal
`default_nettype none
`timescale 1ns/1ps

module sequence_detect #(
    parameter int bit_ticks = iso14443a_pkg::DEFAULT_BIT_TICKS
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   pause,
    output iso14443a_pkg::rx_seq_t seq
);

    localparam int phase_w = $clog2(bit_ticks);
    localparam logic [phase_w-1:0] last_phase = phase_w'(bit_ticks - 1);
    localparam logic [phase_w-1:0] half_phase = phase_w'(bit_ticks / 2);

    // idle waits for the first pause, which is always the Z of the SOC
    typedef enum logic {
        idle,
        tracking
    } state_t;

    state_t                state;
    logic [phase_w-1:0]    phase;
    logic                  first_half;
    logic                  second_half;
    logic                  y_seen;
    logic                  pause_first;
    logic                  pause_second;
    iso14443a_pkg::seq_t   period_kind;

    // include the current sample so the last cycle of a period counts too
    assign pause_first  = first_half | (pause && (phase < half_phase));
    assign pause_second = second_half | (pause && (phase >= half_phase));

    always_comb begin
        if (pause_first && pause_second) begin
            period_kind = iso14443a_pkg::SEQ_ERR;
        end else if (pause_first) begin
            period_kind = iso14443a_pkg::SEQ_Z;
        end else if (pause_second) begin
            period_kind = iso14443a_pkg::SEQ_X;
        end else begin
            period_kind = iso14443a_pkg::SEQ_Y;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= idle;
            phase       <= '0;
            first_half  <= 1'b0;
            second_half <= 1'b0;
            y_seen      <= 1'b0;
            seq         <= '0;
        end else begin
            seq.valid <= 1'b0;
            case (state)
                idle: begin
                    // the pause cycle itself is phase 0 of the first period
                    if (pause) begin
                        state       <= tracking;
                        phase       <= phase_w'(1);
                        first_half  <= 1'b1;
                        second_half <= 1'b0;
                        y_seen      <= 1'b0;
                    end
                end
                tracking: begin
                    if (phase == last_phase) begin
                        seq.valid   <= 1'b1;
                        seq.kind    <= period_kind;
                        phase       <= '0;
                        first_half  <= 1'b0;
                        second_half <= 1'b0;
                        y_seen      <= (period_kind == iso14443a_pkg::SEQ_Y);
                        // a second Y in a row means the field went quiet
                        if (y_seen && (period_kind == iso14443a_pkg::SEQ_Y)) begin
                            state <= idle;
                        end
                    end else begin
                        phase       <= phase + 1'b1;
                        first_half  <= pause_first;
                        second_half <= pause_second;
                    end
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: common/iso14443a_pkg.sv
// shared types for the type A card receive path
// sequence kinds, per stage payload structs and bit timing constants
`default_nettype none

package iso14443a_pkg;

    // ========================================================================
    // timing
    // ========================================================================

    // clk cycles in one bit period when the top level does not override it
    localparam int DEFAULT_BIT_TICKS = 16;

    // data bits in a byte, the odd parity bit follows them on the air
    localparam int BYTE_BITS = 8;

    // ========================================================================
    // modified Miller sequences
    // ========================================================================

    // X has the pause in the second half, Z in the first half, Y has none
    // a pause in both halves can not come from a legal encoder
    typedef enum logic [1:0] {
        SEQ_X   = 2'd0,
        SEQ_Y   = 2'd1,
        SEQ_Z   = 2'd2,
        SEQ_ERR = 2'd3
    } seq_t;

    // one classified bit period, valid pulses for a single cycle
    typedef struct packed {
        logic valid;
        seq_t kind;
    } rx_seq_t;

    // ========================================================================
    // decoded stream and frame events
    // ========================================================================

    // output of the frame decoder, value only means something with valid
    typedef struct packed {
        logic valid;
        logic soc;
        logic eoc;
        logic sequence_error;
        logic value;
    } rx_bit_t;

    // one event towards the rest of the card
    // data_bits is 0 for a whole byte and 1 to 7 for the partial byte at eoc
    typedef struct packed {
        logic       soc;
        logic       eoc;
        logic       sequence_error;
        logic       parity_error;
        logic       data_valid;
        logic [2:0] data_bits;
        logic [7:0] data;
    } frame_event_t;

endpackage

`default_nettype wire
